/* z2_pkg.sv */
package z2_pkg;

  // ------------------------------------------------------------------
  // bus and memory geometry
  // ------------------------------------------------------------------
  localparam int ZADDR_W         = 24;
  localparam int ZDATA_W         = 16;
  localparam int FB_ADDR_W       = 12;  // 4096 words
  localparam int COORD_W         = 6;
  localparam int FB_STRIDE_SHIFT = 6;   // 64 pixels per row

  localparam logic [ZADDR_W-1:0] RAM_SIZE      = 24'h002000;
  localparam logic [ZADDR_W-1:0] REG_BASE      = 24'h00f000;
  localparam logic [ZADDR_W-1:0] REG_SPAN      = 24'h000100;
  localparam logic [ZADDR_W-1:0] AUTOCONF_LOW  = 24'he80000;
  localparam logic [ZADDR_W-1:0] AUTOCONF_HIGH = 24'he80080;

  localparam int WQ_DEPTH = 16;
  localparam int WQ_PTR_W = 4;

  // ------------------------------------------------------------------
  // state and register encodings
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    S_CONFIGURING,
    S_IDLE,
    S_READ_WAIT,
    S_READ_HOLD,
    S_WRITE_WAIT,
    S_WRITE_HOLD
  } zorro_state_e;

  typedef enum logic {
    A_READY,
    A_READ_WAIT
  } arb_state_e;

  typedef enum logic [7:0] {
    R_BLT_X1      = 8'h20,
    R_BLT_Y1      = 8'h22,
    R_BLT_X2      = 8'h24,
    R_BLT_Y2      = 8'h26,
    R_BLT_RGB     = 8'h28,
    R_BLT_CTRL    = 8'h2a,
    R_BASE_HI     = 8'h40,
    R_BASE_LO     = 8'h42,
    R_CFG_BASE_HI = 8'h48,
    R_CFG_BASE_LO = 8'h4a,
    R_CFG_SHUTUP  = 8'h4c
  } reg_off_e;

  // autoconfig nibbles live in bits 15:12, most are stored inverted
  function automatic logic [ZDATA_W-1:0] autoconf_rom(input logic [7:0] off);
    case (off)
      8'h00:   autoconf_rom = 16'hc000;  // zorro ii board type
      8'h02:   autoconf_rom = 16'h1000;  // size code
      8'h04:   autoconf_rom = 16'hf000;  // product number
      8'h06:   autoconf_rom = 16'he000;
      8'h40:   autoconf_rom = 16'h0000;  // interrupt bits, not inverted
      8'h42:   autoconf_rom = 16'h0000;
      default: autoconf_rom = 16'hf000;  // inverted zero
    endcase
  endfunction

endpackage

/* write_queue.sv */
module write_queue #(
  parameter int DEPTH = z2_pkg::WQ_DEPTH
) (
  input  logic                         z_sample_clk,
  input  logic                         znRST,
  input  logic                         push_i,
  input  logic [z2_pkg::FB_ADDR_W-1:0] push_addr_i,
  input  logic [1:0]                   push_be_i,
  input  logic [15:0]                  push_data_i,
  input  logic                         pop_i,
  output logic                         empty_o,
  output logic                         full_o,
  output logic [z2_pkg::FB_ADDR_W-1:0] head_addr_o,
  output logic [1:0]                   head_be_o,
  output logic [15:0]                  head_data_o
);
  import z2_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [FB_ADDR_W-1:0] addr_mem [DEPTH];
  logic [1:0]           be_mem   [DEPTH];
  logic [15:0]          data_mem [DEPTH];
  logic [PTR_W-1:0]     wptr;
  logic [PTR_W-1:0]     rptr;
  logic [PTR_W:0]       count;
  logic                 do_push;
  logic                 do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == (PTR_W+1)'(DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge z_sample_clk) begin
    if (do_push) begin
      addr_mem[wptr] <= push_addr_i;
      be_mem[wptr]   <= push_be_i;
      data_mem[wptr] <= push_data_i;
    end
  end

  always_ff @(posedge z_sample_clk) begin
    if (!znRST) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_push) wptr <= wptr + 1'b1;
      if (do_pop) rptr <= rptr + 1'b1;
      count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  // oldest entry, visible without a pop
  assign head_addr_o = addr_mem[rptr];
  assign head_be_o   = be_mem[rptr];
  assign head_data_o = data_mem[rptr];

endmodule

/* fb_ram.sv */
module fb_ram (
  input  logic                         z_sample_clk,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [1:0]                   be_i,
  input  logic [z2_pkg::FB_ADDR_W-1:0] addr_i,
  input  logic [15:0]                  wdata_i,
  output logic [15:0]                  rdata_o
);
  import z2_pkg::*;

  logic [15:0] mem [1 << FB_ADDR_W];

  always_ff @(posedge z_sample_clk) begin
    if (en_i) begin
      if (we_i) begin
        if (be_i[1]) mem[addr_i][15:8] <= wdata_i[15:8];  // upper byte, uds
        if (be_i[0]) mem[addr_i][7:0]  <= wdata_i[7:0];
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* ram_arbiter.sv */
module ram_arbiter (
  input  logic                         z_sample_clk,
  input  logic                         znRST,
  input  logic                         wr_req_i,
  input  logic [z2_pkg::FB_ADDR_W-1:0] wr_addr_i,
  input  logic [1:0]                   wr_be_i,
  input  logic [15:0]                  wr_data_i,
  output logic                         wq_full_o,
  input  logic                         rd_req_i,
  input  logic [z2_pkg::FB_ADDR_W-1:0] rd_addr_i,
  output logic                         rd_done_o,
  output logic [15:0]                  rd_data_o,
  input  logic                         blt_req_i,
  input  logic [z2_pkg::FB_ADDR_W-1:0] blt_addr_i,
  input  logic [15:0]                  blt_data_i,
  output logic                         blt_gnt_o
);
  import z2_pkg::*;

  arb_state_e           state;
  logic                 wq_empty;
  logic                 wq_pop;
  logic [FB_ADDR_W-1:0] head_addr;
  logic [1:0]           head_be;
  logic [15:0]          head_data;
  logic                 ram_en;
  logic                 ram_we;
  logic [1:0]           ram_be;
  logic [FB_ADDR_W-1:0] ram_addr;
  logic [15:0]          ram_wdata;
  logic [15:0]          ram_rdata;

  write_queue #(
    .DEPTH(1 << WQ_PTR_W)
  ) wq0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .push_i      (wr_req_i),
    .push_addr_i (wr_addr_i),
    .push_be_i   (wr_be_i),
    .push_data_i (wr_data_i),
    .pop_i       (wq_pop),
    .empty_o     (wq_empty),
    .full_o      (wq_full_o),
    .head_addr_o (head_addr),
    .head_be_o   (head_be),
    .head_data_o (head_data)
  );

  fb_ram ram0 (
    .z_sample_clk(z_sample_clk),
    .en_i        (ram_en),
    .we_i        (ram_we),
    .be_i        (ram_be),
    .addr_i      (ram_addr),
    .wdata_i     (ram_wdata),
    .rdata_o     (ram_rdata)
  );

  // ------------------------------------------------------------------
  // fixed priority: queue, then bus read, then blitter
  // ------------------------------------------------------------------
  always_comb begin
    wq_pop    = 1'b0;
    blt_gnt_o = 1'b0;
    ram_en    = 1'b0;
    ram_we    = 1'b0;
    ram_be    = 2'b11;
    ram_addr  = rd_addr_i;
    ram_wdata = blt_data_i;
    if (state == A_READY) begin
      if (!wq_empty) begin
        wq_pop    = 1'b1;
        ram_en    = 1'b1;
        ram_we    = 1'b1;
        ram_be    = head_be;
        ram_addr  = head_addr;
        ram_wdata = head_data;
      end else if (rd_req_i) begin
        ram_en = 1'b1;
      end else if (blt_req_i) begin
        ram_en    = 1'b1;
        ram_we    = 1'b1;
        ram_addr  = blt_addr_i;
        blt_gnt_o = 1'b1;
      end
    end
  end

  always_ff @(posedge z_sample_clk) begin
    if (!znRST) begin
      state <= A_READY;
    end else begin
      case (state)
        A_READY:     if (wq_empty && rd_req_i) state <= A_READ_WAIT;
        A_READ_WAIT: state <= A_READY;  // ram data valid this cycle
        default:     state <= A_READY;
      endcase
    end
  end

  assign rd_done_o = (state == A_READ_WAIT);
  assign rd_data_o = ram_rdata;

endmodule

/* blitter.sv */
module blitter (
  input  logic                         z_sample_clk,
  input  logic                         znRST,
  input  logic [z2_pkg::COORD_W-1:0]   x1_i,
  input  logic [z2_pkg::COORD_W-1:0]   y1_i,
  input  logic [z2_pkg::COORD_W-1:0]   x2_i,
  input  logic [z2_pkg::COORD_W-1:0]   y2_i,
  input  logic [15:0]                  rgb_i,
  input  logic                         start_i,
  output logic                         busy_o,
  output logic                         req_o,
  output logic [z2_pkg::FB_ADDR_W-1:0] addr_o,
  output logic [15:0]                  data_o,
  input  logic                         gnt_i
);
  import z2_pkg::*;

  logic [COORD_W-1:0] cur_x;
  logic [COORD_W-1:0] cur_y;
  logic [COORD_W-1:0] x1_q;
  logic [COORD_W-1:0] x2_q;
  logic [COORD_W-1:0] y2_q;
  logic [15:0]        rgb_q;
  logic               busy;

  always_ff @(posedge z_sample_clk) begin
    if (!znRST) begin
      busy <= 1'b0;
    end else if (!busy) begin
      if (start_i) begin  // latch rectangle and colour
        busy  <= 1'b1;
        cur_x <= x1_i;
        cur_y <= y1_i;
        x1_q  <= x1_i;
        x2_q  <= x2_i;
        y2_q  <= y2_i;
        rgb_q <= rgb_i;
      end
    end else if (gnt_i) begin
      if (cur_x >= x2_q) begin
        cur_x <= x1_q;  // next row
        if (cur_y >= y2_q) busy <= 1'b0;
        else cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  assign busy_o = busy;
  assign req_o  = busy;
  assign addr_o = (FB_ADDR_W'(cur_y) << FB_STRIDE_SHIFT) | FB_ADDR_W'(cur_x);
  assign data_o = rgb_q;

endmodule

/* zorro_slave.sv */
module zorro_slave (
  input  logic                        z_sample_clk,
  input  logic                        znRST,
  input  logic                        zas_n_i,
  input  logic                        zuds_n_i,
  input  logic                        zlds_n_i,
  input  logic                        zread_i,
  input  logic                        zcfgin_n_i,
  input  logic [z2_pkg::ZADDR_W-1:0]  za_i,
  input  logic [15:0]                 zd_i,
  output logic [15:0]                 zd_o,
  output logic                        zd_oe_o,
  output logic                        slave_n_o,
  output logic                        xrdy_o,
  output logic                        cfgout_n_o,
  output logic [z2_pkg::COORD_W-1:0]  blt_x1_o,
  output logic [z2_pkg::COORD_W-1:0]  blt_y1_o,
  output logic [z2_pkg::COORD_W-1:0]  blt_x2_o,
  output logic [z2_pkg::COORD_W-1:0]  blt_y2_o,
  output logic [15:0]                 blt_rgb_o,
  output logic                        blt_start_o,
  input  logic                        blt_busy_i,
  output logic                        wr_req_o,
  output logic [z2_pkg::FB_ADDR_W-1:0] wr_addr_o,
  output logic [1:0]                  wr_be_o,
  output logic [15:0]                 wr_data_o,
  input  logic                        wq_full_i,
  output logic                        rd_req_o,
  output logic [z2_pkg::FB_ADDR_W-1:0] rd_addr_o,
  input  logic                        rd_done_i,
  input  logic [15:0]                 rd_data_i
);
  import z2_pkg::*;

  // ------------------------------------------------------------------
  // input synchronizers
  // ------------------------------------------------------------------
  logic [1:0]         as_sync;
  logic [2:0]         uds_sync;
  logic [2:0]         lds_sync;
  logic [1:0]         read_sync;
  logic [1:0]         cfgin_sync;
  logic [ZADDR_W-1:0] za_q1;
  logic [ZADDR_W-1:0] za_q2;
  logic [ZDATA_W-1:0] zd_q1;
  logic [ZDATA_W-1:0] zd_q2;

  always_ff @(posedge z_sample_clk) begin
    if (!znRST) begin
      as_sync    <= 2'b11;
      uds_sync   <= 3'b111;
      lds_sync   <= 3'b111;
      read_sync  <= 2'b00;
      cfgin_sync <= 2'b11;
    end else begin
      as_sync    <= {as_sync[0], zas_n_i};
      uds_sync   <= {uds_sync[1:0], zuds_n_i};
      lds_sync   <= {lds_sync[1:0], zlds_n_i};
      read_sync  <= {read_sync[0], zread_i};
      cfgin_sync <= {cfgin_sync[0], zcfgin_n_i};
    end
  end

  always_ff @(posedge z_sample_clk) begin
    za_q1 <= za_i;
    za_q2 <= za_q1;
    zd_q1 <= zd_i;
    zd_q2 <= zd_q1;
  end

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  zorro_state_e       state;
  logic [ZADDR_W-1:0] base_addr;
  logic [ZADDR_W-1:0] reg_low;
  logic [ZADDR_W-1:0] fb_off;
  logic               as_low;
  logic               addr_stable;
  logic               strobe_ok;
  logic               bus_read;
  logic               in_auto;
  logic               in_ram;
  logic               in_reg;
  reg_off_e           reg_off;
  logic [ZDATA_W-1:0] reg_rdata;

  assign as_low      = ~as_sync[1];
  assign addr_stable = (za_q2 == za_q1);
  assign bus_read    = read_sync[1];
  // both strobes settled and at least one active
  assign strobe_ok   = (uds_sync[2] == uds_sync[1]) && (lds_sync[2] == lds_sync[1]) &&
                       (!uds_sync[2] || !lds_sync[2]);

  assign reg_low = base_addr + REG_BASE;
  assign fb_off  = za_q1 - base_addr;
  assign reg_off = reg_off_e'(za_q1[7:0]);

  assign in_auto = as_low && addr_stable && (za_q1 >= AUTOCONF_LOW) && (za_q1 < AUTOCONF_HIGH);
  assign in_ram  = as_low && addr_stable && (za_q1 >= base_addr) &&
                   (za_q1 < base_addr + RAM_SIZE);
  assign in_reg  = as_low && addr_stable && (za_q1 >= reg_low) && (za_q1 < reg_low + REG_SPAN);

  // register readback mux
  always_comb begin
    case (reg_off)
      R_BLT_X1:   reg_rdata = ZDATA_W'(blt_x1_o);
      R_BLT_Y1:   reg_rdata = ZDATA_W'(blt_y1_o);
      R_BLT_X2:   reg_rdata = ZDATA_W'(blt_x2_o);
      R_BLT_Y2:   reg_rdata = ZDATA_W'(blt_y2_o);
      R_BLT_RGB:  reg_rdata = blt_rgb_o;
      R_BLT_CTRL: reg_rdata = blt_busy_i ? 16'hffff : 16'h0000;
      R_BASE_HI:  reg_rdata = ZDATA_W'(base_addr[23:16]);
      R_BASE_LO:  reg_rdata = base_addr[15:0];
      default:    reg_rdata = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // bus state machine
  // ------------------------------------------------------------------
  logic [ZDATA_W-1:0]   data_q;
  logic                 dataout;
  logic                 slaven;
  logic                 xrdy;
  logic                 configured;
  logic [FB_ADDR_W-1:0] fb_addr_q;

  always_ff @(posedge z_sample_clk) begin
    if (!znRST) begin
      state       <= S_CONFIGURING;
      dataout     <= 1'b0;
      slaven      <= 1'b0;
      xrdy        <= 1'b1;
      configured  <= 1'b0;
      base_addr   <= '0;
      rd_req_o    <= 1'b0;
      wr_req_o    <= 1'b0;
      blt_start_o <= 1'b0;
      blt_x1_o    <= '0;
      blt_y1_o    <= '0;
      blt_x2_o    <= '0;
      blt_y2_o    <= '0;
      blt_rgb_o   <= '0;
    end else begin
      wr_req_o    <= 1'b0;  // strobes last one cycle
      blt_start_o <= 1'b0;
      case (state)
        S_CONFIGURING: begin
          if (in_auto && !cfgin_sync[1]) begin
            if (bus_read) begin
              data_q  <= autoconf_rom(za_q1[7:0]);
              dataout <= 1'b1;
              slaven  <= 1'b1;
            end else if (strobe_ok) begin
              case (reg_off)
                R_CFG_BASE_HI: base_addr[23:20] <= zd_q2[15:12];
                R_CFG_BASE_LO: begin
                  base_addr[19:16] <= zd_q2[15:12];  // low nibble completes config
                  configured       <= 1'b1;
                  state            <= S_WRITE_HOLD;
                end
                R_CFG_SHUTUP: begin
                  configured <= 1'b1;
                  state      <= S_WRITE_HOLD;
                end
                default: ;
              endcase
            end
          end else begin
            dataout <= 1'b0;
            slaven  <= 1'b0;
          end
        end

        S_IDLE: begin
          dataout <= 1'b0;
          slaven  <= 1'b0;
          xrdy    <= 1'b1;
          if (bus_read && in_ram) begin
            fb_addr_q <= fb_off[FB_ADDR_W:1];
            rd_req_o  <= 1'b1;
            xrdy      <= 1'b0;  // hold cpu until data is back
            state     <= S_READ_WAIT;
          end else if (!bus_read && in_ram) begin
            fb_addr_q <= fb_off[FB_ADDR_W:1];
            state     <= S_WRITE_WAIT;
          end else if (bus_read && in_reg) begin
            data_q  <= reg_rdata;
            dataout <= 1'b1;
            slaven  <= 1'b1;
            state   <= S_READ_HOLD;
          end else if (!bus_read && in_reg && strobe_ok) begin
            case (reg_off)
              R_BLT_X1:   blt_x1_o    <= zd_q2[COORD_W-1:0];
              R_BLT_Y1:   blt_y1_o    <= zd_q2[COORD_W-1:0];
              R_BLT_X2:   blt_x2_o    <= zd_q2[COORD_W-1:0];
              R_BLT_Y2:   blt_y2_o    <= zd_q2[COORD_W-1:0];
              R_BLT_RGB:  blt_rgb_o   <= zd_q2;
              R_BLT_CTRL: blt_start_o <= zd_q2[8];
              default: ;
            endcase
            state <= S_WRITE_HOLD;
          end
        end

        S_READ_WAIT: begin
          if (!as_low) begin  // cycle abandoned
            rd_req_o <= 1'b0;
            xrdy     <= 1'b1;
            state    <= S_IDLE;
          end else if (rd_done_i) begin
            rd_req_o <= 1'b0;
            xrdy     <= 1'b1;
            data_q   <= rd_data_i;
            dataout  <= 1'b1;
            slaven   <= 1'b1;
            state    <= S_READ_HOLD;
          end
        end

        S_READ_HOLD: begin
          if (!as_low) begin
            dataout <= 1'b0;
            slaven  <= 1'b0;
            state   <= S_IDLE;
          end
        end

        S_WRITE_WAIT: begin
          if (!as_low) begin
            xrdy  <= 1'b1;
            state <= S_IDLE;
          end else if (strobe_ok) begin
            if (wq_full_i) begin
              xrdy <= 1'b0;  // back-pressure
            end else begin
              wr_req_o  <= 1'b1;
              wr_be_o   <= {~uds_sync[2], ~lds_sync[2]};
              wr_data_o <= zd_q2;
              xrdy      <= 1'b1;
              state     <= S_WRITE_HOLD;
            end
          end
        end

        S_WRITE_HOLD: begin
          xrdy <= 1'b1;
          if (!as_low) state <= S_IDLE;
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  assign zd_o       = data_q;
  assign zd_oe_o    = dataout;
  assign slave_n_o  = ~slaven;
  assign xrdy_o     = xrdy;
  assign cfgout_n_o = ~configured;
  assign wr_addr_o  = fb_addr_q;
  assign rd_addr_o  = fb_addr_q;

endmodule

/* z2_top.sv */
module z2_top (
  input  logic                        z_sample_clk,
  input  logic                        znRST,
  input  logic                        zas_n_i,
  input  logic                        zuds_n_i,
  input  logic                        zlds_n_i,
  input  logic                        zread_i,
  input  logic                        zcfgin_n_i,
  input  logic [z2_pkg::ZADDR_W-1:0]  za_i,
  input  logic [15:0]                 zd_i,
  output logic [15:0]                 zd_o,
  output logic                        zd_oe_o,
  output logic                        slave_n_o,
  output logic                        xrdy_o,
  output logic                        cfgout_n_o
);
  import z2_pkg::*;

  // ------------------------------------------------------------------
  // slave to blitter
  // ------------------------------------------------------------------
  logic [COORD_W-1:0]   blt_x1;
  logic [COORD_W-1:0]   blt_y1;
  logic [COORD_W-1:0]   blt_x2;
  logic [COORD_W-1:0]   blt_y2;
  logic [15:0]          blt_rgb;
  logic                 blt_start;
  logic                 blt_busy;

  // memory requests
  logic                 wr_req;
  logic [FB_ADDR_W-1:0] wr_addr;
  logic [1:0]           wr_be;
  logic [15:0]          wr_data;
  logic                 wq_full;
  logic                 rd_req;
  logic [FB_ADDR_W-1:0] rd_addr;
  logic                 rd_done;
  logic [15:0]          rd_data;
  logic                 blt_req;
  logic [FB_ADDR_W-1:0] blt_addr;
  logic [15:0]          blt_data;
  logic                 blt_gnt;

  zorro_slave slave0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .zas_n_i     (zas_n_i),
    .zuds_n_i    (zuds_n_i),
    .zlds_n_i    (zlds_n_i),
    .zread_i     (zread_i),
    .zcfgin_n_i  (zcfgin_n_i),
    .za_i        (za_i),
    .zd_i        (zd_i),
    .zd_o        (zd_o),
    .zd_oe_o     (zd_oe_o),
    .slave_n_o   (slave_n_o),
    .xrdy_o      (xrdy_o),
    .cfgout_n_o  (cfgout_n_o),
    .blt_x1_o    (blt_x1),
    .blt_y1_o    (blt_y1),
    .blt_x2_o    (blt_x2),
    .blt_y2_o    (blt_y2),
    .blt_rgb_o   (blt_rgb),
    .blt_start_o (blt_start),
    .blt_busy_i  (blt_busy),
    .wr_req_o    (wr_req),
    .wr_addr_o   (wr_addr),
    .wr_be_o     (wr_be),
    .wr_data_o   (wr_data),
    .wq_full_i   (wq_full),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_done_i   (rd_done),
    .rd_data_i   (rd_data)
  );

  blitter blit0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .x1_i        (blt_x1),
    .y1_i        (blt_y1),
    .x2_i        (blt_x2),
    .y2_i        (blt_y2),
    .rgb_i       (blt_rgb),
    .start_i     (blt_start),
    .busy_o      (blt_busy),
    .req_o       (blt_req),
    .addr_o      (blt_addr),
    .data_o      (blt_data),
    .gnt_i       (blt_gnt)
  );

  ram_arbiter arb0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_be_i     (wr_be),
    .wr_data_i   (wr_data),
    .wq_full_o   (wq_full),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_done_o   (rd_done),
    .rd_data_o   (rd_data),
    .blt_req_i   (blt_req),
    .blt_addr_i  (blt_addr),
    .blt_data_i  (blt_data),
    .blt_gnt_o   (blt_gnt)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic z_sample_clk,
  output logic znRST
);
  localparam int HALF_PERIOD = 20;  // 40 unit period
  localparam int RST_CYCLES  = 3;

  initial begin
    z_sample_clk = 1'b0;
    forever #HALF_PERIOD z_sample_clk = ~z_sample_clk;
  end

  // release on a falling edge, after three rising edges in reset
  initial begin
    znRST = 1'b0;
    repeat (RST_CYCLES) @(posedge z_sample_clk);
    @(negedge z_sample_clk);
    znRST = 1'b1;
  end

endmodule

/* tb_z2_asserts.sv */
module tb_z2_asserts (
  input logic z_sample_clk,
  input logic znRST,
  input logic slave_n_i,
  input logic zd_oe_i,
  input logic xrdy_i,
  input logic cfgout_n_i
);

  // data bus is driven whenever the card claims the cycle
  a_slave_drives_data: assert property (
    @(posedge z_sample_clk) disable iff (!znRST)
    !slave_n_i |-> zd_oe_i
  ) else $error("slave_n_o low while zd_oe_o is low");

  // once configured, the card stays configured until reset
  a_cfgout_sticky: assert property (
    @(posedge z_sample_clk) disable iff (!znRST)
    !cfgout_n_i |=> !cfgout_n_i
  ) else $error("cfgout_n_o went high again without a reset");

  a_idle_after_reset: assert property (
    @(posedge z_sample_clk)
    $rose(znRST) |-> (slave_n_i && xrdy_i)
  ) else $error("slave_n_o or xrdy_o low in the first cycle after reset");

endmodule

/* tb_z2.sv */
module tb_z2;
  import z2_pkg::*;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_WRITE_HI,  // uds only
    OP_POLL
  } op_e;

  localparam logic [ZADDR_W-1:0] CARD_BASE = 24'h600000;
  localparam logic [ZADDR_W-1:0] REG_ADDR  = CARD_BASE + REG_BASE;
  localparam int WAIT_LIMIT = 200;  // cycles per handshake
  localparam int POLL_LIMIT = 50;
  localparam int BURST_LEN  = 40;

  logic                 z_sample_clk;
  logic                 znRST;
  logic                 zas_n;
  logic                 zuds_n;
  logic                 zlds_n;
  logic                 zread;
  logic                 zcfgin_n;
  logic [ZADDR_W-1:0]   za;
  logic [15:0]          zd_wr;
  logic [15:0]          zd_o;
  logic                 zd_oe_o;
  logic                 slave_n_o;
  logic                 xrdy_o;
  logic                 cfgout_n_o;

  // stimulus and expect table
  string                t_name[$];
  op_e                  t_op[$];
  logic [ZADDR_W-1:0]   t_addr[$];
  logic [15:0]          t_data[$];
  logic [15:0]          t_exp[$];

  logic [15:0]          fb_model [0:4095];  // expected framebuffer contents
  integer               seed;

  tb_clk_gen clkgen0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST)
  );

  z2_top dut0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .zas_n_i     (zas_n),
    .zuds_n_i    (zuds_n),
    .zlds_n_i    (zlds_n),
    .zread_i     (zread),
    .zcfgin_n_i  (zcfgin_n),
    .za_i        (za),
    .zd_i        (zd_wr),
    .zd_o        (zd_o),
    .zd_oe_o     (zd_oe_o),
    .slave_n_o   (slave_n_o),
    .xrdy_o      (xrdy_o),
    .cfgout_n_o  (cfgout_n_o)
  );

  bind zorro_slave tb_z2_asserts asserts0 (
    .z_sample_clk(z_sample_clk),
    .znRST       (znRST),
    .slave_n_i   (slave_n_o),
    .zd_oe_i     (zd_oe_o),
    .xrdy_i      (xrdy_o),
    .cfgout_n_i  (cfgout_n_o)
  );

  // ------------------------------------------------------------------
  // failure reporting
  // ------------------------------------------------------------------
  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    $display("ERR %s expected %h actual %h", name, exp, act);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("timed out: %s", what);
    abort_run();
  endtask

  // ------------------------------------------------------------------
  // bus cycles, driven on the falling edge
  // ------------------------------------------------------------------
  task automatic bus_read(input logic [ZADDR_W-1:0] addr, output logic [15:0] data);
    int wait_cnt;
    @(negedge z_sample_clk);
    za     = addr;
    zread  = 1'b1;
    zuds_n = 1'b0;
    zlds_n = 1'b0;
    zas_n  = 1'b0;
    wait_cnt = 0;
    while (slave_n_o !== 1'b0) begin
      @(negedge z_sample_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) report_timeout("slave_n_o never went low on a read");
    end
    data   = zd_o;
    zas_n  = 1'b1;
    zuds_n = 1'b1;
    zlds_n = 1'b1;
    zread  = 1'b0;
    wait_cnt = 0;
    while (slave_n_o !== 1'b1) begin
      @(negedge z_sample_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) report_timeout("slave_n_o stayed low after a read");
    end
  endtask

  task automatic bus_write(input logic [ZADDR_W-1:0] addr, input logic [15:0] data,
                           input logic upper_only);
    int wait_cnt;
    @(negedge z_sample_clk);
    za     = addr;
    zd_wr  = data;
    zread  = 1'b0;
    zuds_n = 1'b0;
    zlds_n = upper_only;
    zas_n  = 1'b0;
    repeat (8) @(negedge z_sample_clk);
    wait_cnt = 0;
    while (xrdy_o !== 1'b1) begin  // queue back-pressure
      @(negedge z_sample_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) report_timeout("xrdy_o stayed low during a write");
    end
    zas_n  = 1'b1;
    zuds_n = 1'b1;
    zlds_n = 1'b1;
    repeat (2) @(negedge z_sample_clk);  // bus idle gap
  endtask

  // ------------------------------------------------------------------
  // table building
  // ------------------------------------------------------------------
  function automatic logic [ZADDR_W-1:0] fb_addr(input logic [11:0] widx);
    return CARD_BASE + {11'd0, widx, 1'b0};
  endfunction

  function automatic logic [ZADDR_W-1:0] reg_addr(input logic [7:0] off);
    return REG_ADDR + {16'd0, off};
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic void add_step(input string name, input op_e op,
                                   input logic [ZADDR_W-1:0] addr,
                                   input logic [15:0] data, input logic [15:0] exp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_exp.push_back(exp);
  endfunction

  function automatic void fb_write(input string name, input logic [11:0] widx,
                                   input logic [15:0] d, input logic upper_only);
    if (upper_only) begin
      fb_model[widx][15:8] = d[15:8];  // lower byte untouched
      add_step(name, OP_WRITE_HI, fb_addr(widx), d, 16'h0000);
    end else begin
      fb_model[widx] = d;
      add_step(name, OP_WRITE, fb_addr(widx), d, 16'h0000);
    end
  endfunction

  function automatic void fb_read(input string name, input logic [11:0] widx);
    add_step(name, OP_READ, fb_addr(widx), 16'h0000, fb_model[widx]);
  endfunction

  function automatic void build_table();
    int i;
    int x;
    int y;

    add_step("rom_00", OP_READ, AUTOCONF_LOW + 24'h00, 16'h0000, 16'hc000);
    add_step("rom_02", OP_READ, AUTOCONF_LOW + 24'h02, 16'h0000, 16'h1000);
    add_step("rom_30", OP_READ, AUTOCONF_LOW + 24'h30, 16'h0000, 16'hf000);
    add_step("cfg_base_hi", OP_WRITE, AUTOCONF_LOW + 24'h48, 16'h6000, 16'h0000);
    add_step("cfg_base_lo", OP_WRITE, AUTOCONF_LOW + 24'h4a, 16'h0000, 16'h0000);
    add_step("base_hi_reg", OP_READ, reg_addr(R_BASE_HI), 16'h0000, 16'h0060);

    // round trip with word 0x55a written twice
    for (i = 0; i < 6; i++) begin
      fb_write($sformatf("rt_wr_%0d", i), 12'h010 + 12'(i) * 12'h2a5, rand_word(), 1'b0);
    end
    fb_write("rt_rewrite", 12'h55a, rand_word(), 1'b0);
    for (i = 0; i < 6; i++) begin
      fb_read($sformatf("rt_rd_%0d", i), 12'h010 + 12'(i) * 12'h2a5);
    end

    fb_write("be_full", 12'h300, rand_word(), 1'b0);
    fb_write("be_upper", 12'h300, rand_word(), 1'b1);
    fb_read("be_check", 12'h300);

    // ------------------------------------------------------------------
    // rectangle fill over x 2..5 and y 1..3
    // ------------------------------------------------------------------
    fb_write("outside_1_1", 12'd65, rand_word(), 1'b0);
    fb_write("outside_6_2", 12'd134, rand_word(), 1'b0);
    add_step("blt_x1", OP_WRITE, reg_addr(R_BLT_X1), 16'd2, 16'h0000);
    add_step("blt_y1", OP_WRITE, reg_addr(R_BLT_Y1), 16'd1, 16'h0000);
    add_step("blt_x2", OP_WRITE, reg_addr(R_BLT_X2), 16'd5, 16'h0000);
    add_step("blt_y2", OP_WRITE, reg_addr(R_BLT_Y2), 16'd3, 16'h0000);
    add_step("blt_rgb", OP_WRITE, reg_addr(R_BLT_RGB), 16'h1234, 16'h0000);
    add_step("blt_go", OP_WRITE, reg_addr(R_BLT_CTRL), 16'h0100, 16'h0000);
    add_step("blt_poll", OP_POLL, reg_addr(R_BLT_CTRL), 16'h0000, 16'h0000);
    for (y = 1; y <= 3; y++) begin
      for (x = 2; x <= 5; x++) begin
        fb_model[y * 64 + x] = 16'h1234;
      end
    end
    for (y = 1; y <= 3; y++) begin
      for (x = 2; x <= 5; x++) begin
        fb_read($sformatf("fill_%0d_%0d", x, y), 12'(y * 64 + x));
      end
    end
    fb_read("outside_1_1_rd", 12'd65);
    fb_read("outside_6_2_rd", 12'd134);

    // burst longer than the write queue
    for (i = 0; i < BURST_LEN; i++) begin
      fb_write($sformatf("burst_wr_%0d", i), 12'h800 + 12'(i), rand_word(), 1'b0);
    end
    for (i = 0; i < BURST_LEN; i++) begin
      fb_read($sformatf("burst_rd_%0d", i), 12'h800 + 12'(i));
    end
  endfunction

  task automatic run_step(input int idx);
    logic [15:0] got;
    int          polls;
    case (t_op[idx])
      OP_WRITE:    bus_write(t_addr[idx], t_data[idx], 1'b0);
      OP_WRITE_HI: bus_write(t_addr[idx], t_data[idx], 1'b1);
      OP_READ: begin
        bus_read(t_addr[idx], got);
        assert (got === t_exp[idx])
          else report_mismatch(t_name[idx], t_exp[idx], got);
      end
      OP_POLL: begin
        polls = 0;
        bus_read(t_addr[idx], got);
        while (got !== t_exp[idx]) begin
          polls++;
          if (polls > POLL_LIMIT) begin
            report_timeout($sformatf("%s never read back %h", t_name[idx], t_exp[idx]));
          end
          bus_read(t_addr[idx], got);
        end
      end
      default: ;
    endcase
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int i;
    int wait_cnt;
    zas_n    = 1'b1;
    zuds_n   = 1'b1;
    zlds_n   = 1'b1;
    zread    = 1'b0;
    zcfgin_n = 1'b0;  // first card in the chain
    za       = '0;
    zd_wr    = '0;
    seed     = 32'hf543eb21;
    build_table();

    wait_cnt = 0;
    while (znRST !== 1'b1) begin
      @(negedge z_sample_clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) report_timeout("reset was never released");
    end
    @(negedge z_sample_clk);
    assert (cfgout_n_o === 1'b1)
      else report_mismatch("cfgout_after_reset", 16'h0001, {15'd0, cfgout_n_o});
    assert (slave_n_o === 1'b1)
      else report_mismatch("slave_n_after_reset", 16'h0001, {15'd0, slave_n_o});
    assert (zd_oe_o === 1'b0)
      else report_mismatch("zd_oe_after_reset", 16'h0000, {15'd0, zd_oe_o});
    assert (xrdy_o === 1'b1)
      else report_mismatch("xrdy_after_reset", 16'h0001, {15'd0, xrdy_o});

    for (i = 0; i < t_op.size(); i++) begin
      run_step(i);
    end

    assert (cfgout_n_o === 1'b0)
      else report_mismatch("cfgout_configured", 16'h0000, {15'd0, cfgout_n_o});
    $display("Testbench passed");
    $finish;
  end

endmodule

/* tb.f */
z2_pkg.sv
write_queue.sv
fb_ram.sv
ram_arbiter.sv
blitter.sv
zorro_slave.sv
z2_top.sv
tb_clk_gen.sv
tb_z2_asserts.sv
tb_z2.sv
